// ==== verilog/i3c_target_pkg.sv ====
// Shared constants and types for the I3C standby target, imported by every RTL block
package i3c_target_pkg;

  // Addressing
  localparam int unsigned ADDR_W = 7;
  localparam logic [ADDR_W-1:0] BROADCAST_ADDR = 7'h7E;

  // Broadcast CCC codes handled by the target
  localparam logic [7:0] CCC_ENEC   = 8'h00;
  localparam logic [7:0] CCC_DISEC  = 8'h01;
  localparam logic [7:0] CCC_RSTDAA = 8'h06;
  localparam logic [7:0] CCC_RSTACT = 8'h2A;

  // Event enables: bit 0 interrupt, bit 1 controller role, bit 2 hot-join
  localparam int unsigned EVT_W = 3;

  // RSTACT defining byte values
  localparam logic [7:0] RST_ACT_PERIPH = 8'h01;
  localparam logic [7:0] RST_ACT_ESCAL  = 8'h02;

  // Requester that currently drives the bit engine
  typedef enum logic {
    OWNER_FSM,
    OWNER_CCC
  } owner_e;

  // First byte after START is a header, later bytes are raw codes or data
  typedef union packed {
    struct packed {
      logic [ADDR_W-1:0] addr;
      logic              rnw;
    } hdr;
    logic [7:0] raw;
  } rx_byte_u;

endpackage

// ==== verilog/bus_bit_engine.sv ====
// Bit-level SDR receiver and ACK driver, shared by the target FSM and CCC handler via the arbiter
`timescale 1ns/1ps

module bus_bit_engine (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_det_i,
  input  logic                    stop_det_i,
  input  logic                    scl_posedge_i,
  input  logic                    scl_negedge_i,
  input  logic                    sda_i,
  input  logic                    rx_req_byte_i,
  input  logic                    rx_req_frame_i,
  input  logic                    ack_req_i,
  output logic                    rx_done_o,
  output i3c_target_pkg::rx_byte_u rx_data_o,
  output logic                    rx_parity_ok_o,
  output logic                    parity_err_o,
  output logic                    ack_done_o,
  output logic                    sda_o
);

  logic       busy_q;
  logic       is_frame_q;
  logic [3:0] bit_cnt_q;
  logic [3:0] last_bit;
  logic [8:0] shift_q;
  logic       ack_armed_q;
  logic       parity_good;
  logic       bus_abort;
  logic       rx_req;

  assign bus_abort = start_det_i | stop_det_i;
  assign rx_req    = rx_req_byte_i | rx_req_frame_i;

  // Frames carry a ninth T bit
  assign last_bit = is_frame_q ? 4'd8 : 4'd7;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      is_frame_q  <= 1'b0;
      bit_cnt_q   <= '0;
      rx_done_o   <= 1'b0;
      ack_armed_q <= 1'b0;
      ack_done_o  <= 1'b0;
      sda_o       <= 1'b1;
    end else begin
      rx_done_o  <= 1'b0;
      ack_done_o <= 1'b0;
      if (bus_abort) begin
        busy_q      <= 1'b0;
        ack_armed_q <= 1'b0;
        sda_o       <= 1'b1;
      end else begin
        if (rx_req) begin
          busy_q     <= 1'b1;
          is_frame_q <= rx_req_frame_i;
          bit_cnt_q  <= '0;
        end else if (busy_q && scl_posedge_i) begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
          if (bit_cnt_q == last_bit) begin
            busy_q    <= 1'b0;
            rx_done_o <= 1'b1;
          end
        end
        // ACK holds SDA low for one full SCL low-to-low period
        if (ack_req_i) begin
          ack_armed_q <= 1'b1;
        end else if (scl_negedge_i) begin
          if (ack_armed_q) begin
            ack_armed_q <= 1'b0;
            sda_o       <= 1'b0;
          end else if (!sda_o) begin
            sda_o      <= 1'b1;
            ack_done_o <= 1'b1;
          end
        end
      end
    end
  end

  // MSB first shifter
  always_ff @(posedge clk_i) begin
    if (rx_req) begin
      shift_q <= '0;
    end else if (busy_q && scl_posedge_i) begin
      shift_q <= {shift_q[7:0], sda_i};
    end
  end

  // Odd parity over data plus T bit
  assign parity_good = (shift_q[0] == ~^shift_q[8:1]);

  assign rx_data_o      = is_frame_q ? shift_q[8:1] : shift_q[7:0];
  assign rx_parity_ok_o = ~is_frame_q | parity_good;
  assign parity_err_o   = rx_done_o & is_frame_q & ~parity_good;

endmodule

// ==== verilog/bus_arbiter.sv ====
// Ownership tracking and request/result routing between the two requesters and the bit engine
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     ccc_valid_i,
  input  logic                     ccc_done_i,
  input  logic                     fsm_rx_req_byte_i,
  input  logic                     fsm_rx_req_frame_i,
  input  logic                     fsm_ack_req_i,
  input  logic                     ccc_rx_req_byte_i,
  input  logic                     ccc_rx_req_frame_i,
  input  logic                     eng_rx_done_i,
  input  i3c_target_pkg::rx_byte_u eng_rx_data_i,
  input  logic                     eng_rx_parity_ok_i,
  input  logic                     eng_ack_done_i,
  output logic                     eng_rx_req_byte_o,
  output logic                     eng_rx_req_frame_o,
  output logic                     eng_ack_req_o,
  output logic                     fsm_rx_done_o,
  output i3c_target_pkg::rx_byte_u fsm_rx_data_o,
  output logic                     fsm_rx_parity_ok_o,
  output logic                     fsm_ack_done_o,
  output logic                     ccc_rx_done_o,
  output i3c_target_pkg::rx_byte_u ccc_rx_data_o,
  output logic                     ccc_rx_parity_ok_o
);
  import i3c_target_pkg::*;

  owner_e owner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= OWNER_FSM;
    end else if (owner_q == OWNER_FSM && ccc_valid_i) begin
      owner_q <= OWNER_CCC;
    end else if (owner_q == OWNER_CCC && ccc_done_i) begin
      owner_q <= OWNER_FSM;
    end
  end

  // Non-owner sees all results low
  always_comb begin
    eng_rx_req_byte_o  = 1'b0;
    eng_rx_req_frame_o = 1'b0;
    eng_ack_req_o      = 1'b0;
    fsm_rx_done_o      = 1'b0;
    fsm_rx_data_o      = '0;
    fsm_rx_parity_ok_o = 1'b0;
    fsm_ack_done_o     = 1'b0;
    ccc_rx_done_o      = 1'b0;
    ccc_rx_data_o      = '0;
    ccc_rx_parity_ok_o = 1'b0;
    unique case (owner_q)
      OWNER_FSM: begin
        eng_rx_req_byte_o  = fsm_rx_req_byte_i;
        eng_rx_req_frame_o = fsm_rx_req_frame_i;
        eng_ack_req_o      = fsm_ack_req_i;
        fsm_rx_done_o      = eng_rx_done_i;
        fsm_rx_data_o      = eng_rx_data_i;
        fsm_rx_parity_ok_o = eng_rx_parity_ok_i;
        fsm_ack_done_o     = eng_ack_done_i;
      end
      OWNER_CCC: begin
        eng_rx_req_byte_o  = ccc_rx_req_byte_i;
        eng_rx_req_frame_o = ccc_rx_req_frame_i;
        ccc_rx_done_o      = eng_rx_done_i;
        ccc_rx_data_o      = eng_rx_data_i;
        ccc_rx_parity_ok_o = eng_rx_parity_ok_i;
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/target_fsm.sv ====
// Target transfer FSM: header decode and ACK, CCC hand-off and private-write data push
`timescale 1ns/1ps

module target_fsm (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                target_en_i,
  input  logic                                start_det_i,
  input  logic                                stop_det_i,
  input  logic [i3c_target_pkg::ADDR_W-1:0]   dyn_addr_i,
  input  logic                                dyn_addr_valid_i,
  input  logic                                rx_done_i,
  input  i3c_target_pkg::rx_byte_u            rx_data_i,
  input  logic                                rx_parity_ok_i,
  input  logic                                ack_done_i,
  output logic                                rx_req_byte_o,
  output logic                                rx_req_frame_o,
  output logic                                ack_req_o,
  output logic                                ccc_valid_o,
  output logic [7:0]                          ccc_code_o,
  output logic                                rx_queue_wvalid_o,
  output logic [7:0]                          rx_queue_wdata_o
);
  import i3c_target_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR,
    ST_ACK,
    ST_CCC,
    ST_DATA,
    ST_WAIT
  } state_e;

  state_e state_q;
  logic   bcast_q;
  logic   is_bcast;
  logic   is_own;
  logic   hdr_match;
  logic   frame_ok;

  assign is_bcast  = (rx_data_i.hdr.addr == BROADCAST_ADDR);
  assign is_own    = dyn_addr_valid_i && (rx_data_i.hdr.addr == dyn_addr_i);
  // Reads are not supported, so only write headers are ACKed
  assign hdr_match = !rx_data_i.hdr.rnw && (is_bcast || is_own);
  assign frame_ok  = rx_done_i && rx_parity_ok_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q           <= ST_IDLE;
      bcast_q           <= 1'b0;
      rx_req_byte_o     <= 1'b0;
      rx_req_frame_o    <= 1'b0;
      ack_req_o         <= 1'b0;
      ccc_valid_o       <= 1'b0;
      rx_queue_wvalid_o <= 1'b0;
    end else begin
      rx_req_byte_o     <= 1'b0;
      rx_req_frame_o    <= 1'b0;
      ack_req_o         <= 1'b0;
      ccc_valid_o       <= 1'b0;
      rx_queue_wvalid_o <= 1'b0;
      if (start_det_i) begin
        if (target_en_i) begin
          state_q       <= ST_HDR;
          rx_req_byte_o <= 1'b1;
        end else begin
          state_q <= ST_IDLE;
        end
      end else if (stop_det_i) begin
        state_q <= ST_IDLE;
      end else begin
        unique case (state_q)
          ST_HDR: begin
            if (rx_done_i) begin
              if (hdr_match) begin
                state_q   <= ST_ACK;
                ack_req_o <= 1'b1;
                bcast_q   <= is_bcast;
              end else begin
                state_q <= ST_WAIT;
              end
            end
          end
          ST_ACK: begin
            if (ack_done_i) begin
              state_q        <= bcast_q ? ST_CCC : ST_DATA;
              rx_req_frame_o <= 1'b1;
            end
          end
          // CCC handler takes over the bus until STOP or repeated START
          ST_CCC: begin
            if (rx_done_i) begin
              state_q     <= ST_WAIT;
              ccc_valid_o <= rx_parity_ok_i;
            end
          end
          ST_DATA: begin
            if (rx_done_i) begin
              rx_req_frame_o    <= 1'b1;
              rx_queue_wvalid_o <= rx_parity_ok_i;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_ok && state_q == ST_CCC) begin
      ccc_code_o <= rx_data_i.raw;
    end
    if (frame_ok && state_q == ST_DATA) begin
      rx_queue_wdata_o <= rx_data_i.raw;
    end
  end

endmodule

// ==== verilog/ccc_handler.sv ====
// Broadcast CCC handler for ENEC, DISEC, RSTDAA and RSTACT with the reset-action outputs
`timescale 1ns/1ps

module ccc_handler (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_det_i,
  input  logic                             stop_det_i,
  input  logic                             ccc_valid_i,
  input  logic [7:0]                       ccc_code_i,
  input  logic                             rx_done_i,
  input  i3c_target_pkg::rx_byte_u         rx_data_i,
  input  logic                             rx_parity_ok_i,
  input  logic                             peripheral_reset_done_i,
  output logic                             rx_req_frame_o,
  output logic                             ccc_done_o,
  output logic [i3c_target_pkg::EVT_W-1:0] events_en_o,
  output logic                             rstdaa_o,
  output logic [7:0]                       rst_action_o,
  output logic                             rst_action_valid_o,
  output logic                             peripheral_reset_o,
  output logic                             escalated_reset_o
);
  import i3c_target_pkg::*;

  logic       busy_q;
  logic [7:0] code_q;
  logic       frame_ok;

  assign frame_ok = busy_q && rx_done_i && rx_parity_ok_i;

  // Bus returns to the FSM in time for the header after a repeated START
  assign ccc_done_o = busy_q & (start_det_i | stop_det_i);

  // RSTDAA has no defining byte
  assign rstdaa_o = ccc_valid_i & (ccc_code_i == CCC_RSTDAA);

  always_ff @(posedge clk_i) begin
    if (ccc_valid_i) begin
      code_q <= ccc_code_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q         <= 1'b0;
      rx_req_frame_o <= 1'b0;
    end else begin
      rx_req_frame_o <= 1'b0;
      if (ccc_done_o) begin
        busy_q <= 1'b0;
      end else if (ccc_valid_i) begin
        busy_q         <= 1'b1;
        rx_req_frame_o <= 1'b1;
      end else if (busy_q && rx_done_i) begin
        rx_req_frame_o <= 1'b1;
      end
    end
  end

  // Defining bytes, unknown codes fall through
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      events_en_o        <= '0;
      rst_action_o       <= '0;
      rst_action_valid_o <= 1'b0;
    end else begin
      rst_action_valid_o <= 1'b0;
      if (frame_ok) begin
        unique case (code_q)
          CCC_ENEC:   events_en_o <= events_en_o | rx_data_i.raw[EVT_W-1:0];
          CCC_DISEC:  events_en_o <= events_en_o & ~rx_data_i.raw[EVT_W-1:0];
          CCC_RSTACT: begin
            rst_action_o       <= rx_data_i.raw;
            rst_action_valid_o <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Peripheral reset waits for acknowledge, escalated reset is sticky
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      if (rst_action_valid_o && rst_action_o == RST_ACT_PERIPH) begin
        peripheral_reset_o <= 1'b1;
      end
      if (peripheral_reset_done_i) begin
        peripheral_reset_o <= 1'b0;
      end
      if (rst_action_valid_o && rst_action_o == RST_ACT_ESCAL) begin
        escalated_reset_o <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/i3c_target_top.sv ====
// Top level of the I3C standby target, connecting bit engine, arbiter, target FSM and CCC handler
`timescale 1ns/1ps

module i3c_target_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              target_en_i,
  input  logic                              start_det_i,
  input  logic                              stop_det_i,
  input  logic                              scl_posedge_i,
  input  logic                              scl_negedge_i,
  input  logic                              sda_i,
  output logic                              sda_o,
  input  logic [i3c_target_pkg::ADDR_W-1:0] dyn_addr_i,
  input  logic                              dyn_addr_valid_i,
  output logic                              rx_queue_wvalid_o,
  output logic [7:0]                        rx_queue_wdata_o,
  output logic                              parity_err_o,
  output logic [i3c_target_pkg::EVT_W-1:0]  events_en_o,
  output logic                              rstdaa_o,
  output logic [7:0]                        rst_action_o,
  output logic                              rst_action_valid_o,
  output logic                              peripheral_reset_o,
  input  logic                              peripheral_reset_done_i,
  output logic                              escalated_reset_o
);
  import i3c_target_pkg::*;

  // Engine side
  logic     eng_rx_req_byte;
  logic     eng_rx_req_frame;
  logic     eng_ack_req;
  logic     eng_rx_done;
  rx_byte_u eng_rx_data;
  logic     eng_rx_parity_ok;
  logic     eng_ack_done;

  // Target FSM side
  logic     fsm_rx_req_byte;
  logic     fsm_rx_req_frame;
  logic     fsm_ack_req;
  logic     fsm_rx_done;
  rx_byte_u fsm_rx_data;
  logic     fsm_rx_parity_ok;
  logic     fsm_ack_done;

  // CCC handler side
  logic       ccc_rx_req_frame;
  logic       ccc_rx_done;
  rx_byte_u   ccc_rx_data;
  logic       ccc_rx_parity_ok;
  logic       ccc_valid;
  logic [7:0] ccc_code;
  logic       ccc_done;

  bus_bit_engine u_engine (
    .clk_i,
    .rst_ni,
    .start_det_i,
    .stop_det_i,
    .scl_posedge_i,
    .scl_negedge_i,
    .sda_i,
    .rx_req_byte_i  (eng_rx_req_byte),
    .rx_req_frame_i (eng_rx_req_frame),
    .ack_req_i      (eng_ack_req),
    .rx_done_o      (eng_rx_done),
    .rx_data_o      (eng_rx_data),
    .rx_parity_ok_o (eng_rx_parity_ok),
    .parity_err_o,
    .ack_done_o     (eng_ack_done),
    .sda_o
  );

  // CCC handler only ever receives frames
  bus_arbiter u_arbiter (
    .clk_i,
    .rst_ni,
    .ccc_valid_i        (ccc_valid),
    .ccc_done_i         (ccc_done),
    .fsm_rx_req_byte_i  (fsm_rx_req_byte),
    .fsm_rx_req_frame_i (fsm_rx_req_frame),
    .fsm_ack_req_i      (fsm_ack_req),
    .ccc_rx_req_byte_i  (1'b0),
    .ccc_rx_req_frame_i (ccc_rx_req_frame),
    .eng_rx_done_i      (eng_rx_done),
    .eng_rx_data_i      (eng_rx_data),
    .eng_rx_parity_ok_i (eng_rx_parity_ok),
    .eng_ack_done_i     (eng_ack_done),
    .eng_rx_req_byte_o  (eng_rx_req_byte),
    .eng_rx_req_frame_o (eng_rx_req_frame),
    .eng_ack_req_o      (eng_ack_req),
    .fsm_rx_done_o      (fsm_rx_done),
    .fsm_rx_data_o      (fsm_rx_data),
    .fsm_rx_parity_ok_o (fsm_rx_parity_ok),
    .fsm_ack_done_o     (fsm_ack_done),
    .ccc_rx_done_o      (ccc_rx_done),
    .ccc_rx_data_o      (ccc_rx_data),
    .ccc_rx_parity_ok_o (ccc_rx_parity_ok)
  );

  target_fsm u_target_fsm (
    .clk_i,
    .rst_ni,
    .target_en_i,
    .start_det_i,
    .stop_det_i,
    .dyn_addr_i,
    .dyn_addr_valid_i,
    .rx_done_i         (fsm_rx_done),
    .rx_data_i         (fsm_rx_data),
    .rx_parity_ok_i    (fsm_rx_parity_ok),
    .ack_done_i        (fsm_ack_done),
    .rx_req_byte_o     (fsm_rx_req_byte),
    .rx_req_frame_o    (fsm_rx_req_frame),
    .ack_req_o         (fsm_ack_req),
    .ccc_valid_o       (ccc_valid),
    .ccc_code_o        (ccc_code),
    .rx_queue_wvalid_o,
    .rx_queue_wdata_o
  );

  ccc_handler u_ccc_handler (
    .clk_i,
    .rst_ni,
    .start_det_i,
    .stop_det_i,
    .ccc_valid_i             (ccc_valid),
    .ccc_code_i              (ccc_code),
    .rx_done_i               (ccc_rx_done),
    .rx_data_i               (ccc_rx_data),
    .rx_parity_ok_i          (ccc_rx_parity_ok),
    .peripheral_reset_done_i,
    .rx_req_frame_o          (ccc_rx_req_frame),
    .ccc_done_o              (ccc_done),
    .events_en_o,
    .rstdaa_o,
    .rst_action_o,
    .rst_action_valid_o,
    .peripheral_reset_o,
    .escalated_reset_o
  );

endmodule

// ==== tb/i3c_target_asserts.sv ====
// Concurrent protocol checks bound into the I3C target top level during simulation
`timescale 1ns/1ps

module i3c_target_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic start_det_i,
  input logic stop_det_i,
  input logic sda_o,
  input logic rx_queue_wvalid_o,
  input logic parity_err_o,
  input logic rst_action_valid_o,
  input logic escalated_reset_o
);

  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  wvalid_perr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_queue_wvalid_o && parity_err_o))
    else begin
      $error("Queue write and parity error in the same cycle");
      fail_cnt++;
    end

  escal_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$fell(escalated_reset_o))
    else begin
      $error("Escalated reset dropped without a block reset");
      fail_cnt++;
    end

  act_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rst_action_valid_o |=> !rst_action_valid_o)
    else begin
      $error("Reset action valid held for more than one cycle");
      fail_cnt++;
    end

  // SDA released on every START and STOP
  sda_free_on_cond: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (start_det_i || stop_det_i) |-> sda_o)
    else begin
      $error("SDA driven low during START or STOP");
      fail_cnt++;
    end

endmodule

bind i3c_target_top i3c_target_asserts u_asserts (.*);

// ==== tb/tb_i3c_target.sv ====
// Table-driven testbench for the I3C target, with a bus model and a reference model
`timescale 1ns/1ps

module tb_i3c_target;
  import i3c_target_pkg::*;

  localparam int unsigned WAIT_LIMIT = 200;
  localparam logic [6:0]  DYN_ADDR   = 7'h3A;
  localparam logic [2:0]  NO_FLIP    = 3'd7;

  // Data bytes: byte 0 in the low bits
  typedef struct packed {
    logic            en;
    logic [6:0]      addr;
    logic            rnw;
    logic            has_ccc;
    logic [7:0]      ccc;
    logic [2:0]      nbytes;
    logic [3:0][7:0] data;
    logic            rnd;
    logic [2:0]      flip;
    logic            exp_ack;
  } row_t;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       target_en_i;
  logic       start_det_i;
  logic       stop_det_i;
  logic       scl_posedge_i;
  logic       scl_negedge_i;
  logic       sda_i;
  logic       sda_o;
  logic [6:0] dyn_addr_i;
  logic       dyn_addr_valid_i;
  logic       rx_queue_wvalid_o;
  logic [7:0] rx_queue_wdata_o;
  logic       parity_err_o;
  logic [2:0] events_en_o;
  logic       rstdaa_o;
  logic [7:0] rst_action_o;
  logic       rst_action_valid_o;
  logic       peripheral_reset_o;
  logic       peripheral_reset_done_i;
  logic       escalated_reset_o;

  row_t       rows[$];
  logic [7:0] got_q[$];
  logic [7:0] exp_q[$];
  logic [7:0] lfsr_q = 8'd42;
  int         err_cnt = 0;
  int         timeout_cnt = 0;
  int         perr_cnt = 0;
  int         rstdaa_cnt = 0;
  int         act_cnt = 0;
  int         exp_perr_cnt = 0;
  int         exp_rstdaa_cnt = 0;
  int         exp_act_cnt = 0;
  logic [2:0] exp_ev = '0;
  logic [7:0] exp_act = '0;
  logic       exp_periph = 1'b0;
  logic       exp_escal = 1'b0;

  i3c_target_top u_dut (.*);

  always #20 clk_i = ~clk_i;

  // Output pulses are collected before the edge updates them
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (rx_queue_wvalid_o) got_q.push_back(rx_queue_wdata_o);
      if (parity_err_o) perr_cnt++;
      if (rstdaa_o) rstdaa_cnt++;
      if (rst_action_valid_o) act_cnt++;
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    int         i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      b = {b[6:0], lfsr_q[0]};
    end
    return b;
  endfunction

  task automatic add_row(input logic en, input logic [6:0] addr, input logic rnw,
                         input logic has_ccc, input logic [7:0] ccc, input logic [2:0] n,
                         input logic [31:0] data, input logic rnd, input logic [2:0] flip,
                         input logic ack);
    rows.push_back({en, addr, rnw, has_ccc, ccc, n, data, rnd, flip, ack});
  endtask

  task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic start_condition();
    start_det_i = 1'b1;
    @(negedge clk_i);
    start_det_i = 1'b0;
    repeat (3) @(negedge clk_i);
  endtask

  task automatic stop_condition();
    stop_det_i = 1'b1;
    @(negedge clk_i);
    stop_det_i = 1'b0;
    repeat (3) @(negedge clk_i);
  endtask

  // One SCL period, SDA seen by the bus at the rising edge
  task automatic clock_bit(input logic b, output logic seen);
    sda_i = b;
    scl_posedge_i = 1'b1;
    seen = sda_o;
    @(negedge clk_i);
    scl_posedge_i = 1'b0;
    repeat (3) @(negedge clk_i);
    scl_negedge_i = 1'b1;
    @(negedge clk_i);
    scl_negedge_i = 1'b0;
    repeat (3) @(negedge clk_i);
    sda_i = 1'b1;
  endtask

  task automatic parity_frame(input logic [7:0] b, input logic flip);
    logic seen;
    int   i;
    for (i = 7; i >= 0; i--) clock_bit(b[i], seen);
    clock_bit(~^b ^ flip, seen);
  endtask

  task automatic run_transfer(input row_t t, output logic ack);
    logic       seen;
    logic [7:0] hdr;
    int         i;
    hdr = {t.addr, t.rnw};
    start_condition();
    for (i = 7; i >= 0; i--) clock_bit(hdr[i], seen);
    clock_bit(1'b1, seen);
    ack = !seen;
    if (t.has_ccc) parity_frame(t.ccc, 1'b0);
    for (i = 0; i < t.nbytes; i++) parity_frame(t.data[i], i == t.flip);
    stop_condition();
  endtask

  task automatic apply_defining(input logic [7:0] code, input logic [7:0] b);
    case (code)
      CCC_ENEC:  exp_ev = exp_ev | b[2:0];
      CCC_DISEC: exp_ev = exp_ev & ~b[2:0];
      CCC_RSTACT: begin
        exp_act = b;
        exp_act_cnt++;
        if (b == 8'h01) exp_periph = 1'b1;
        if (b == 8'h02) exp_escal = 1'b1;
      end
      default: ;
    endcase
  endtask

  task automatic predict_row(input row_t t);
    logic acked;
    logic bcast;
    int   i;
    bcast = (t.addr == BROADCAST_ADDR);
    acked = t.en && !t.rnw && (bcast || t.addr == DYN_ADDR);
    if (acked && bcast && t.ccc == CCC_RSTDAA) exp_rstdaa_cnt++;
    for (i = 0; acked && i < t.nbytes; i++) begin
      if (i == t.flip) exp_perr_cnt++;
      else if (bcast) apply_defining(t.ccc, t.data[i]);
      else exp_q.push_back(t.data[i]);
    end
  endtask

  task automatic wait_queue_len(input int n);
    int cyc;
    cyc = 0;
    while (got_q.size() < n && cyc < WAIT_LIMIT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (got_q.size() < n) begin
      $display("Timeout: only %0d of %0d queue writes arrived", got_q.size(), n);
      timeout_cnt++;
    end
  endtask

  task automatic release_periph();
    int cyc;
    peripheral_reset_done_i = 1'b1;
    @(negedge clk_i);
    peripheral_reset_done_i = 1'b0;
    cyc = 0;
    while (peripheral_reset_o && cyc < WAIT_LIMIT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (peripheral_reset_o) begin
      $display("Timeout: peripheral reset stayed high after its acknowledge");
      timeout_cnt++;
    end
    exp_periph = 1'b0;
  endtask

  task automatic check_row(input int r, input row_t t, input logic ack);
    int i;
    expect_value(ack, t.exp_ack, $sformatf("row %0d ACK", r));
    wait_queue_len(exp_q.size());
    expect_value(got_q.size(), exp_q.size(), $sformatf("row %0d queue writes", r));
    for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      expect_value(got_q[i], exp_q[i], $sformatf("row %0d queue byte %0d", r, i));
    end
    got_q.delete();
    exp_q.delete();
    expect_value(perr_cnt, exp_perr_cnt, $sformatf("row %0d parity errors", r));
    expect_value(rstdaa_cnt, exp_rstdaa_cnt, $sformatf("row %0d rstdaa pulses", r));
    expect_value(act_cnt, exp_act_cnt, $sformatf("row %0d reset action pulses", r));
    expect_value(rst_action_o, exp_act, $sformatf("row %0d rst_action_o", r));
    expect_value(events_en_o, exp_ev, $sformatf("row %0d events_en_o", r));
    expect_value(peripheral_reset_o, exp_periph, $sformatf("row %0d periph reset", r));
    expect_value(escalated_reset_o, exp_escal, $sformatf("row %0d escalated reset", r));
  endtask

  initial begin
    row_t cur;
    logic ack_seen;
    int   r;
    int   k;
    int   total;
    rst_ni = 1'b0;
    target_en_i = 1'b1;
    start_det_i = 1'b0;
    stop_det_i = 1'b0;
    scl_posedge_i = 1'b0;
    scl_negedge_i = 1'b0;
    sda_i = 1'b1;
    dyn_addr_i = DYN_ADDR;
    dyn_addr_valid_i = 1'b1;
    peripheral_reset_done_i = 1'b0;

    //      en addr            rnw ccc? code        n  data           rnd flip     ack
    add_row(1, DYN_ADDR,       0,  0,   8'h00,      3, 32'h003C_A511, 0,  NO_FLIP, 1);
    add_row(1, DYN_ADDR,       0,  0,   8'h00,      4, 32'h0,         1,  NO_FLIP, 1);
    add_row(1, 7'h22,          0,  0,   8'h00,      2, 32'h0000_5A5A, 0,  NO_FLIP, 0);
    add_row(1, DYN_ADDR,       1,  0,   8'h00,      1, 32'h0000_0077, 0,  NO_FLIP, 0);
    add_row(0, DYN_ADDR,       0,  0,   8'h00,      2, 32'h0000_1234, 0,  NO_FLIP, 0);
    add_row(1, DYN_ADDR,       0,  0,   8'h00,      3, 32'h0,         1,  3'd1,    1);
    add_row(1, BROADCAST_ADDR, 0,  1,   CCC_ENEC,   2, 32'h0000_0205, 0,  NO_FLIP, 1);
    add_row(1, BROADCAST_ADDR, 0,  1,   CCC_DISEC,  1, 32'h0000_0004, 0,  NO_FLIP, 1);
    add_row(1, BROADCAST_ADDR, 0,  1,   CCC_RSTDAA, 0, 32'h0,         0,  NO_FLIP, 1);
    add_row(1, BROADCAST_ADDR, 0,  1,   CCC_RSTACT, 1, 32'h0000_0001, 0,  NO_FLIP, 1);
    add_row(1, BROADCAST_ADDR, 0,  1,   CCC_RSTACT, 1, 32'h0000_0002, 0,  NO_FLIP, 1);
    add_row(1, BROADCAST_ADDR, 0,  1,   CCC_DISEC,  2, 32'h0000_0201, 0,  3'd0,    1);
    add_row(1, DYN_ADDR,       0,  0,   8'h00,      2, 32'h0000_ADDE, 0,  NO_FLIP, 1);
    add_row(1, BROADCAST_ADDR, 0,  1,   8'h9F,      1, 32'h0000_0007, 0,  NO_FLIP, 1);
    add_row(1, DYN_ADDR,       0,  0,   8'h00,      2, 32'h0,         1,  NO_FLIP, 1);

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    expect_value(sda_o, 1'b1, "sda_o after reset");
    expect_value(events_en_o, 3'b000, "events_en_o after reset");
    expect_value(rst_action_o, 8'h00, "rst_action_o after reset");
    expect_value({peripheral_reset_o, escalated_reset_o}, 2'b00, "resets after reset");

    for (r = 0; r < rows.size(); r++) begin
      cur = rows[r];
      for (k = 0; cur.rnd && k < cur.nbytes; k++) cur.data[k] = rand_byte();
      target_en_i = cur.en;
      run_transfer(cur, ack_seen);
      predict_row(cur);
      check_row(r, cur, ack_seen);
      if (exp_periph) release_periph();
    end

    total = err_cnt + timeout_cnt + u_dut.u_asserts.fail_cnt;
    $display("Errors: %0d checks, %0d timeouts, %0d assertions", err_cnt, timeout_cnt,
             u_dut.u_asserts.fail_cnt);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/i3c_target_pkg.sv
verilog/bus_bit_engine.sv
verilog/bus_arbiter.sv
verilog/target_fsm.sv
verilog/ccc_handler.sv
verilog/i3c_target_top.sv
tb/i3c_target_asserts.sv
tb/tb_i3c_target.sv

// ==== Bender.yml ====
package:
  name: i3c_target

sources:
  - files:
      - verilog/i3c_target_pkg.sv
      - verilog/bus_bit_engine.sv
      - verilog/bus_arbiter.sv
      - verilog/target_fsm.sv
      - verilog/ccc_handler.sv
      - verilog/i3c_target_top.sv
  - target: test
    files:
      - tb/i3c_target_asserts.sv
      - tb/tb_i3c_target.sv
